// File: Makefile
VERILATOR  ?= verilator
TOP        ?= lsu_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= SIMULATION PASSED
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: build.f
design/lsu_pkg.sv
design/lsu_split.sv
design/lsu_write_buffer.sv
design/mem_arbiter.sv
design/data_memory.sv
design/lsu_top.sv
testbench/lsu_checker.sv
testbench/lsu_tb.sv

// File: design/data_memory.sv
`timescale 1ns/1ps

module data_memory (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       mem_req_i,
  input  logic                       mem_we_i,
  input  logic [lsu_pkg::addr_w-1:2] mem_addr_i,
  input  logic [3:0]                 mem_be_i,
  input  logic [31:0]                mem_wdata_i,
  output logic                       mem_rvalid_o,
  output logic [31:0]                mem_rdata_o
);
  import lsu_pkg::*;

  lsu_word_u mem [mem_words];
  lsu_word_u wdata;

  assign wdata.word = mem_wdata_i;

  // Every request is granted on sight and answered one cycle later
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rvalid_o <= 1'b0;
    end else begin
      mem_rvalid_o <= mem_req_i;
    end
  end

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk) begin
    if (mem_req_i) begin
      if (mem_we_i) begin
        // Only enabled lanes change
        for (int i = 0; i < 4; i++) begin
          if (mem_be_i[i]) begin
            mem[mem_addr_i].lanes[i] <= wdata.lanes[i];
          end
        end
      end else begin
        mem_rdata_o <= mem[mem_addr_i].word;
      end
    end
  end

endmodule

// File: design/lsu_pkg.sv
package lsu_pkg;

  ////////////////////
  // Sizes
  ////////////////////

  // Byte address width, giving a 1 KiB data memory
  localparam int addr_w = 10;

  // Number of 32-bit words behind the arbiter
  localparam int mem_words = 256;

  // The LSU never has more bus transfers than this in flight
  localparam int max_outstanding = 2;

  ////////////////////
  // Types
  ////////////////////

  // Access size as seen on the LSU request port
  typedef enum logic [1:0] {
    size_byte = 2'b00,
    size_half = 2'b01,
    size_word = 2'b10
  } lsu_size_e;

  // One bus word, seen either whole or as four byte lanes
  // Lane 0 is the least significant byte
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lanes;
  } lsu_word_u;

  // Outstanding transfer counter, wide enough for max_outstanding
  typedef logic [1:0] cnt_t;

endpackage

// File: design/lsu_split.sv
`timescale 1ns/1ps

module lsu_split (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  lsu_pkg::lsu_size_e         lsu_size_i,
  input  logic [lsu_pkg::addr_w-1:0] lsu_addr_i,
  input  logic [31:0]                lsu_wdata_i,
  output logic                       lsu_ready_o,
  output logic                       lsu_valid_o,
  output logic [31:0]                lsu_rdata_o,
  output logic                       lsu_busy_o,
  input  logic                       wb_empty_i,
  output logic                       wb_push_o,
  output logic [lsu_pkg::addr_w-1:2] st_addr_o,
  output logic [3:0]                 st_be_o,
  output logic [31:0]                st_wdata_o,
  output logic                       ld_req_o,
  output logic [lsu_pkg::addr_w-1:2] ld_addr_o,
  input  logic                       ld_gnt_i,
  input  logic                       bus_rvalid_i,
  input  logic [31:0]                bus_rdata_i,
  input  logic                       st_granted_i
);
  import lsu_pkg::*;

  logic              accept;
  logic [3:0]        size_mask;
  logic [7:0]        be_wide;
  logic              crosses;
  logic [addr_w-1:2] lo_waddr;
  logic [addr_w-1:2] hi_waddr;
  lsu_word_u         wdata_rot;
  logic              st_pend;
  logic              ld_done;

  logic              init_q;
  cnt_t              cnt_q;
  logic              split_q;
  logic [addr_w-1:2] hi_addr_q;
  logic [3:0]        hi_be_q;
  lsu_word_u         st_data_q;
  logic              ld_active_q;
  logic              ld_req_q;
  logic              ld_two_q;
  logic              ld_lo_seen_q;
  logic [addr_w-1:2] ld_addr_q;
  logic [1:0]        ld_off_q;
  logic [3:0]        ld_keep_q;
  lsu_word_u         ld_lo_q;
  lsu_word_u         lo_src;
  lsu_word_u         hi_src;
  lsu_word_u         merged;

  ////////////////////
  // Request decode
  ////////////////////

  // New work is taken only with no load running, no split half waiting
  // and an empty write buffer, so stores and loads stay in program order
  assign lsu_ready_o = init_q && !ld_active_q && !split_q && wb_empty_i;
  assign accept      = lsu_req_i && lsu_ready_o;

  always_comb begin
    case (lsu_size_i)
      size_byte: size_mask = 4'b0001;
      size_half: size_mask = 4'b0011;
      default:   size_mask = 4'b1111;
    endcase
  end

  // Upper nibble holds the lanes that spill into the next word
  assign be_wide  = {4'b0000, size_mask} << lsu_addr_i[1:0];
  assign crosses  = |be_wide[7:4];
  assign lo_waddr = lsu_addr_i[addr_w-1:2];
  assign hi_waddr = lo_waddr + 1'b1;

  // Rotate store bytes to their lanes; both halves share this word
  always_comb begin
    logic [1:0] lane;
    lane = '0;
    wdata_rot.word = '0;
    for (int i = 0; i < 4; i++) begin
      lane = lsu_addr_i[1:0] + 2'(i);
      wdata_rot.lanes[lane] = lsu_wdata_i[8*i +: 8];
    end
  end

  ////////////////////
  // Store path
  ////////////////////

  // The high half of a split store waits here until the buffer drains
  assign st_pend    = split_q && !ld_active_q;
  assign wb_push_o  = (accept && lsu_we_i) || (st_pend && wb_empty_i);
  assign st_addr_o  = st_pend ? hi_addr_q : lo_waddr;
  assign st_be_o    = st_pend ? hi_be_q : be_wide[3:0];
  assign st_wdata_o = st_pend ? st_data_q.word : wdata_rot.word;

  ////////////////////
  // Load path
  ////////////////////

  // Hold back a load transfer when the bus already carries the limit
  assign ld_req_o  = ld_req_q && (cnt_q < cnt_t'(max_outstanding));
  assign ld_addr_o = ld_addr_q;

  // The last response of a load is the only one for a single-word access
  assign ld_done = ld_active_q && bus_rvalid_i && (!ld_two_q || ld_lo_seen_q);

  // Result lane i comes from byte (offset + i) of the low and high words
  always_comb begin
    logic [1:0] lane;
    lane = '0;
    hi_src.word = bus_rdata_i;
    lo_src = ld_two_q ? ld_lo_q : hi_src;
    merged.word = '0;
    for (int i = 0; i < 4; i++) begin
      lane = ld_off_q + 2'(i);
      if (!ld_keep_q[i]) begin
        // Loads are zero-extended
        merged.lanes[i] = 8'h00;
      end else if (({1'b0, ld_off_q} + 3'(i)) < 3'd4) begin
        merged.lanes[i] = lo_src.lanes[lane];
      end else begin
        merged.lanes[i] = hi_src.lanes[lane];
      end
    end
  end

  assign lsu_busy_o = (cnt_q != '0) || !wb_empty_i || split_q || ld_active_q;

  ////////////////////
  // Control state
  ////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      init_q       <= 1'b0;
      cnt_q        <= '0;
      split_q      <= 1'b0;
      ld_active_q  <= 1'b0;
      ld_req_q     <= 1'b0;
      ld_two_q     <= 1'b0;
      ld_lo_seen_q <= 1'b0;
      lsu_valid_o  <= 1'b0;
    end else begin
      init_q      <= 1'b1;
      // Every LSU grant gets exactly one response, stores included
      cnt_q       <= cnt_q + cnt_t'(ld_gnt_i || st_granted_i) - cnt_t'(bus_rvalid_i);
      lsu_valid_o <= ld_done;
      if (accept) begin
        split_q      <= crosses;
        ld_active_q  <= !lsu_we_i;
        ld_req_q     <= !lsu_we_i;
        ld_two_q     <= crosses;
        ld_lo_seen_q <= 1'b0;
      end else begin
        if (st_pend && wb_empty_i) begin
          split_q <= 1'b0;
        end
        // First grant of a split load moves on to the high word
        if (ld_gnt_i) begin
          if (split_q) begin
            split_q <= 1'b0;
          end else begin
            ld_req_q <= 1'b0;
          end
        end
        if (ld_active_q && bus_rvalid_i) begin
          if (ld_two_q && !ld_lo_seen_q) begin
            ld_lo_seen_q <= 1'b1;
          end else begin
            ld_active_q <= 1'b0;
          end
        end
      end
    end
  end

  // Payload registers for the pending half and the load merge
  always_ff @(posedge clk) begin
    if (accept) begin
      hi_addr_q <= hi_waddr;
      hi_be_q   <= be_wide[7:4];
      st_data_q <= wdata_rot;
      ld_addr_q <= lo_waddr;
      ld_off_q  <= lsu_addr_i[1:0];
      ld_keep_q <= size_mask;
    end else if (ld_gnt_i) begin
      ld_addr_q <= hi_addr_q;
    end
    if (ld_active_q && bus_rvalid_i && !ld_lo_seen_q) begin
      ld_lo_q.word <= bus_rdata_i;
    end
    if (ld_done) begin
      lsu_rdata_o <= merged.word;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  a_cnt_limit: assert property (@(posedge clk) disable iff (!rst_n)
    cnt_q <= cnt_t'(max_outstanding))
    else $error("lsu_split: outstanding count above limit");

  // A response with nothing in flight means the arbiter misrouted it
  a_no_spurious_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    bus_rvalid_i |-> (cnt_q != '0))
    else $error("lsu_split: rvalid with zero outstanding count");

  // A granted transfer stays counted until its response, so busy follows it
  a_busy_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    (ld_gnt_i || st_granted_i) |=> lsu_busy_o)
    else $error("lsu_split: transfer granted but busy is low while it is in flight");

  // A load completes only after its high half went out
  // So the next request always finds the split flag clear
  a_split_clear_on_done: assert property (@(posedge clk) disable iff (!rst_n)
    lsu_valid_o |-> !split_q)
    else $error("lsu_split: split flag still set when a load completes");

endmodule

// File: design/lsu_top.sv
`timescale 1ns/1ps

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  lsu_pkg::lsu_size_e         lsu_size_i,
  input  logic [lsu_pkg::addr_w-1:0] lsu_addr_i,
  input  logic [31:0]                lsu_wdata_i,
  output logic                       lsu_ready_o,
  output logic                       lsu_valid_o,
  output logic [31:0]                lsu_rdata_o,
  output logic                       lsu_busy_o,
  input  logic                       fetch_req_i,
  input  logic [lsu_pkg::addr_w-1:2] fetch_addr_i,
  output logic                       fetch_gnt_o,
  output logic                       fetch_rvalid_o,
  output logic [31:0]                fetch_rdata_o
);

  logic                       wb_empty;
  logic                       wb_push;
  logic [lsu_pkg::addr_w-1:2] st_addr;
  logic [3:0]                 st_be;
  logic [31:0]                st_wdata;
  logic                       ld_req;
  logic [lsu_pkg::addr_w-1:2] ld_addr;
  logic                       ld_gnt;
  logic                       wb_req;
  logic [lsu_pkg::addr_w-1:2] wb_addr;
  logic [3:0]                 wb_be;
  logic [31:0]                wb_wdata;
  logic                       wb_gnt;
  logic                       lsu_bus_req;
  logic [lsu_pkg::addr_w-1:2] lsu_bus_addr;
  logic [3:0]                 lsu_bus_be;
  logic                       lsu_gnt;
  logic                       lsu_rvalid;
  logic                       mem_req;
  logic                       mem_we;
  logic [lsu_pkg::addr_w-1:2] mem_addr;
  logic [3:0]                 mem_be;
  logic [31:0]                mem_wdata;
  logic                       mem_rvalid;
  logic [31:0]                mem_rdata;

  // Loads wait for an empty buffer, so at most one of these requests is up
  assign lsu_bus_req  = wb_req || ld_req;
  assign lsu_bus_addr = wb_req ? wb_addr : ld_addr;
  assign lsu_bus_be   = wb_req ? wb_be : 4'hf;
  assign wb_gnt       = lsu_gnt && wb_req;
  assign ld_gnt       = lsu_gnt && !wb_req;

  // Read data is shared; the rvalid strobes say who it belongs to
  assign fetch_rdata_o = mem_rdata;

  lsu_split u_split (
    .clk, .rst_n,
    .lsu_req_i, .lsu_we_i, .lsu_size_i, .lsu_addr_i, .lsu_wdata_i,
    .lsu_ready_o, .lsu_valid_o, .lsu_rdata_o, .lsu_busy_o,
    .wb_empty_i (wb_empty), .wb_push_o (wb_push),
    .st_addr_o (st_addr), .st_be_o (st_be), .st_wdata_o (st_wdata),
    .ld_req_o (ld_req), .ld_addr_o (ld_addr), .ld_gnt_i (ld_gnt),
    .bus_rvalid_i (lsu_rvalid), .bus_rdata_i (mem_rdata), .st_granted_i (wb_gnt)
  );

  lsu_write_buffer u_wbuf (
    .clk, .rst_n,
    .wb_push_i (wb_push), .wb_addr_i (st_addr), .wb_be_i (st_be), .wb_wdata_i (st_wdata),
    .wb_empty_o (wb_empty),
    .bus_req_o (wb_req), .bus_addr_o (wb_addr), .bus_be_o (wb_be), .bus_wdata_o (wb_wdata),
    .bus_gnt_i (wb_gnt)
  );

  mem_arbiter u_arb (
    .clk, .rst_n,
    .lsu_req_i (lsu_bus_req), .lsu_we_i (wb_req), .lsu_addr_i (lsu_bus_addr),
    .lsu_be_i (lsu_bus_be), .lsu_wdata_i (wb_wdata),
    .lsu_gnt_o (lsu_gnt), .lsu_rvalid_o (lsu_rvalid),
    .fetch_req_i, .fetch_addr_i, .fetch_gnt_o, .fetch_rvalid_o,
    .mem_req_o (mem_req), .mem_we_o (mem_we), .mem_addr_o (mem_addr),
    .mem_be_o (mem_be), .mem_wdata_o (mem_wdata), .mem_rvalid_i (mem_rvalid)
  );

  data_memory u_mem (
    .clk, .rst_n,
    .mem_req_i (mem_req), .mem_we_i (mem_we), .mem_addr_i (mem_addr),
    .mem_be_i (mem_be), .mem_wdata_i (mem_wdata),
    .mem_rvalid_o (mem_rvalid), .mem_rdata_o (mem_rdata)
  );

endmodule

// File: design/lsu_write_buffer.sv
`timescale 1ns/1ps

module lsu_write_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wb_push_i,
  input  logic [lsu_pkg::addr_w-1:2] wb_addr_i,
  input  logic [3:0]                 wb_be_i,
  input  logic [31:0]                wb_wdata_i,
  output logic                       wb_empty_o,
  output logic                       bus_req_o,
  output logic [lsu_pkg::addr_w-1:2] bus_addr_o,
  output logic [3:0]                 bus_be_o,
  output logic [31:0]                bus_wdata_o,
  input  logic                       bus_gnt_i
);

  logic full_q;

  // A full entry is a standing bus request
  assign wb_empty_o = !full_q;
  assign bus_req_o  = full_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (wb_push_i) begin
      full_q <= 1'b1;
    end else if (bus_gnt_i) begin
      full_q <= 1'b0;
    end
  end

  // Store transfer payload, loaded only into an empty entry
  always_ff @(posedge clk) begin
    if (wb_push_i) begin
      bus_addr_o  <= wb_addr_i;
      bus_be_o    <= wb_be_i;
      bus_wdata_o <= wb_wdata_i;
    end
  end

  ////////////////////
  // Assertions
  ////////////////////

  // The LSU must see the empty flag before pushing
  a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
    wb_push_i |-> !full_q)
    else $error("lsu_write_buffer: push into a full buffer");

  a_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (bus_req_o && !bus_gnt_i) |=>
      bus_req_o && $stable(bus_addr_o) && $stable(bus_be_o) && $stable(bus_wdata_o))
    else $error("lsu_write_buffer: request dropped or payload changed before grant");

endmodule

// File: design/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  logic [lsu_pkg::addr_w-1:2] lsu_addr_i,
  input  logic [3:0]                 lsu_be_i,
  input  logic [31:0]                lsu_wdata_i,
  output logic                       lsu_gnt_o,
  output logic                       lsu_rvalid_o,
  input  logic                       fetch_req_i,
  input  logic [lsu_pkg::addr_w-1:2] fetch_addr_i,
  output logic                       fetch_gnt_o,
  output logic                       fetch_rvalid_o,
  output logic                       mem_req_o,
  output logic                       mem_we_o,
  output logic [lsu_pkg::addr_w-1:2] mem_addr_o,
  output logic [3:0]                 mem_be_o,
  output logic [31:0]                mem_wdata_o,
  input  logic                       mem_rvalid_i
);

  logic       last_fetch_q;
  logic       pick_lsu;
  logic [1:0] tag_q;
  logic [1:0] tag_cnt_q;
  logic [1:0] tag_d;
  logic [1:0] tag_cnt_d;

  ////////////////////
  // Selection
  ////////////////////

  // On a tie, the port that did not win last time goes first
  assign pick_lsu    = lsu_req_i && (!fetch_req_i || last_fetch_q);
  assign lsu_gnt_o   = pick_lsu;
  assign fetch_gnt_o = fetch_req_i && !pick_lsu;

  // The memory grants whatever it sees, so a request here is a grant
  assign mem_req_o   = lsu_req_i || fetch_req_i;
  assign mem_we_o    = pick_lsu && lsu_we_i;
  assign mem_addr_o  = pick_lsu ? lsu_addr_i : fetch_addr_i;
  assign mem_be_o    = pick_lsu ? lsu_be_i : 4'hf;
  assign mem_wdata_o = lsu_wdata_i;

  ////////////////////
  // Response routing
  ////////////////////

  // Tag bit 1 means the fetch port owns that response; entry 0 is the oldest
  assign lsu_rvalid_o   = mem_rvalid_i && !tag_q[0];
  assign fetch_rvalid_o = mem_rvalid_i && tag_q[0];

  always_comb begin
    tag_d     = tag_q;
    tag_cnt_d = tag_cnt_q;
    if (mem_rvalid_i) begin
      tag_d     = {1'b0, tag_q[1]};
      tag_cnt_d = tag_cnt_d - 2'd1;
    end
    if (mem_req_o) begin
      tag_d[tag_cnt_d[0]] = fetch_gnt_o;
      tag_cnt_d           = tag_cnt_d + 2'd1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      last_fetch_q <= 1'b0;
      tag_q        <= '0;
      tag_cnt_q    <= '0;
    end else begin
      if (mem_req_o) begin
        last_fetch_q <= fetch_gnt_o;
      end
      tag_q     <= tag_d;
      tag_cnt_q <= tag_cnt_d;
    end
  end

  // Each memory request belongs to exactly one port, and no grant goes out without one
  a_one_grant: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({lsu_gnt_o, fetch_gnt_o}) && (mem_req_o == (lsu_gnt_o || fetch_gnt_o)))
    else $error("mem_arbiter: grants do not match the memory request");

  // With the single-cycle memory, each grant comes back to its owner next cycle
  a_grant_owner: assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_o |=> (lsu_rvalid_o == $past(lsu_gnt_o)) && (fetch_rvalid_o == $past(fetch_gnt_o)))
    else $error("mem_arbiter: response routed to the wrong port");

endmodule

// File: testbench/lsu_checker.sv
`timescale 1ns/1ps

module lsu_checker (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       lsu_req_i,
  input  logic                       lsu_we_i,
  input  lsu_pkg::lsu_size_e         lsu_size_i,
  input  logic [lsu_pkg::addr_w-1:0] lsu_addr_i,
  input  logic [31:0]                lsu_wdata_i,
  input  logic                       lsu_ready_i,
  input  logic                       lsu_valid_i,
  input  logic [31:0]                lsu_rdata_i,
  input  logic                       lsu_busy_i,
  input  logic                       fetch_req_i,
  input  logic [lsu_pkg::addr_w-1:2] fetch_addr_i,
  input  logic                       fetch_gnt_i,
  input  logic                       fetch_rvalid_i,
  input  logic [31:0]                fetch_rdata_i,
  input  logic                       end_check_i,
  output int                         data_errs_o,
  output int                         proto_errs_o,
  output int                         checks_o
);
  import lsu_pkg::*;

  // Byte-wide picture of the data memory as the program sees it
  logic [7:0]  model_mem [1 << addr_w];
  // Expected results, oldest first, since both paths complete in order
  logic [31:0] load_q [$];
  logic [31:0] fetch_q [$];

  int   data_errs = 0;
  int   proto_errs = 0;
  int   checks = 0;
  int   ready_wait = 0;
  logic ready_seen = 1'b0;

  assign data_errs_o  = data_errs;
  assign proto_errs_o = proto_errs;
  assign checks_o     = checks;

  function automatic int size_bytes(lsu_size_e size);
    case (size)
      size_byte: return 1;
      size_half: return 2;
      default:   return 4;
    endcase
  endfunction

  // Byte i of the result is memory byte addr+i, upper bytes stay zero
  function automatic logic [31:0] read_model(logic [addr_w-1:0] addr, int n);
    logic [31:0]       v;
    logic [addr_w-1:0] a;
    v = '0;
    for (int i = 0; i < n; i++) begin
      a = addr + addr_w'(i);
      v[8*i +: 8] = model_mem[a];
    end
    return v;
  endfunction

  task automatic write_model(logic [addr_w-1:0] addr, int n, logic [31:0] data);
    logic [addr_w-1:0] a;
    for (int i = 0; i < n; i++) begin
      a = addr + addr_w'(i);
      model_mem[a] = data[8*i +: 8];
    end
  endtask

  ////////////////////
  // Sampling
  ////////////////////

  // Everything is looked at on the falling edge, when inputs and outputs have settled
  always @(negedge clk) begin
    logic [31:0] exp;
    exp = '0;
    if (!rst_n) begin
      if (lsu_ready_i || lsu_valid_i || lsu_busy_i || fetch_gnt_i || fetch_rvalid_i) begin
        $display("Outputs are not idle during reset at %0t ns", $time);
        proto_errs++;
      end
    end else begin
      // lsu_ready_o comes up in the first cycle after reset release
      if (!ready_seen) begin
        if (lsu_ready_i) begin
          ready_seen = 1'b1;
        end else begin
          ready_wait++;
          if (ready_wait == 2) begin
            $display("lsu_ready_o did not rise in the first cycle after reset");
            proto_errs++;
          end
        end
      end

      // Completions are retired before new requests are recorded
      if (lsu_valid_i) begin
        if (load_q.size() == 0) begin
          $display("Load completion at %0t ns with no load outstanding", $time);
          proto_errs++;
        end else begin
          exp = load_q.pop_front();
          checks++;
          if (lsu_rdata_i !== exp) begin
            $display("Fail at %0t ns: lsu_rdata_o = %08h, expected %08h",
                     $time, lsu_rdata_i, exp);
            data_errs++;
          end
        end
      end
      // A load that was accepted and has not returned keeps the LSU busy
      if (load_q.size() != 0 && !lsu_busy_i) begin
        $display("lsu_busy_o is low at %0t ns while a load is outstanding", $time);
        proto_errs++;
      end
      if (lsu_req_i && lsu_ready_i) begin
        if (lsu_we_i) begin
          write_model(lsu_addr_i, size_bytes(lsu_size_i), lsu_wdata_i);
        end else begin
          load_q.push_back(read_model(lsu_addr_i, size_bytes(lsu_size_i)));
        end
      end

      if (fetch_rvalid_i) begin
        if (fetch_q.size() == 0) begin
          $display("Fetch response at %0t ns with no fetch outstanding", $time);
          proto_errs++;
        end else begin
          exp = fetch_q.pop_front();
          checks++;
          if (fetch_rdata_i !== exp) begin
            $display("Fail at %0t ns: fetch_rdata_o = %08h, expected %08h",
                     $time, fetch_rdata_i, exp);
            data_errs++;
          end
        end
      end
      if (fetch_req_i && fetch_gnt_i) begin
        fetch_q.push_back(read_model({fetch_addr_i, 2'b00}, 4));
      end

      ////////////////////
      // End of run
      ////////////////////

      if (end_check_i) begin
        if (lsu_busy_i) begin
          $display("lsu_busy_o is still high at the end of the run");
          proto_errs++;
        end
        if (load_q.size() != 0) begin
          $display("%0d loads were accepted but never completed", load_q.size());
          proto_errs++;
        end
        if (fetch_q.size() != 0) begin
          $display("%0d fetches were granted but never answered", fetch_q.size());
          proto_errs++;
        end
        if (!ready_seen) begin
          $display("lsu_ready_o never rose after reset");
          proto_errs++;
        end
      end
    end
  end

endmodule

// File: testbench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb;
  import lsu_pkg::*;

  localparam logic [31:0] seed        = 32'hdb8b49ee;
  localparam int          n_fill      = 256;
  localparam int          n_ops       = 400;
  localparam int          n_fetch     = 120;
  // First word of the fetch region, the upper half of memory
  localparam int          fetch_base  = 128;
  localparam int          cycle_limit = 20 * (n_fill + n_ops + n_fetch);
  localparam time         drive_dly   = 10;

  logic              clk;
  logic              rst_n;
  logic              lsu_req_i;
  logic              lsu_we_i;
  lsu_size_e         lsu_size_i;
  logic [addr_w-1:0] lsu_addr_i;
  logic [31:0]       lsu_wdata_i;
  logic              lsu_ready_o;
  logic              lsu_valid_o;
  logic [31:0]       lsu_rdata_o;
  logic              lsu_busy_o;
  logic              fetch_req_i;
  logic [addr_w-1:2] fetch_addr_i;
  logic              fetch_gnt_o;
  logic              fetch_rvalid_o;
  logic [31:0]       fetch_rdata_o;
  logic              end_check;
  int                data_errs;
  int                proto_errs;
  int                checks;
  int                cycles = 0;
  // Separate LFSR states keep the two stimulus streams independent of process order
  logic [31:0]       lsu_lfsr;
  logic [31:0]       fetch_lfsr;
  logic [31:0]       bits;

  lsu_top dut (.*);

  lsu_checker u_checker (
    .clk, .rst_n,
    .lsu_req_i, .lsu_we_i, .lsu_size_i, .lsu_addr_i, .lsu_wdata_i,
    .lsu_ready_i (lsu_ready_o), .lsu_valid_i (lsu_valid_o),
    .lsu_rdata_i (lsu_rdata_o), .lsu_busy_i (lsu_busy_o),
    .fetch_req_i, .fetch_addr_i, .fetch_gnt_i (fetch_gnt_o),
    .fetch_rvalid_i (fetch_rvalid_o), .fetch_rdata_i (fetch_rdata_o),
    .end_check_i (end_check),
    .data_errs_o (data_errs), .proto_errs_o (proto_errs), .checks_o (checks)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  ////////////////////
  // Helpers
  ////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(inout logic [31:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      st = lfsr_next(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #drive_dly;
  endtask

  // Holds the request until lsu_ready_o is seen with it
  task automatic lsu_access(input logic we, input lsu_size_e size,
                            input logic [addr_w-1:0] addr, input logic [31:0] wdata);
    logic accepted;
    accepted    = 1'b0;
    lsu_req_i   = 1'b1;
    lsu_we_i    = we;
    lsu_size_i  = size;
    lsu_addr_i  = addr;
    lsu_wdata_i = wdata;
    while (!accepted) begin
      @(negedge clk);
      accepted = lsu_ready_o;
      next_cycle();
    end
    lsu_req_i = 1'b0;
  endtask

  task automatic fetch_read(input logic [addr_w-1:2] waddr);
    logic granted;
    granted      = 1'b0;
    fetch_req_i  = 1'b1;
    fetch_addr_i = waddr;
    while (!granted) begin
      @(negedge clk);
      granted = fetch_gnt_o;
      next_cycle();
    end
    fetch_req_i = 1'b0;
    do @(negedge clk); while (!fetch_rvalid_o);
    next_cycle();
  endtask

  // Waits until no load, no split half and no buffered store is left in the LSU
  task automatic wait_ready();
    do @(negedge clk); while (!lsu_ready_o);
    next_cycle();
  endtask

  ////////////////////
  // Phase two traffic
  ////////////////////

  task automatic lsu_traffic();
    logic [31:0]       v;
    logic              we;
    lsu_size_e         size;
    logic [addr_w-1:0] addr;
    logic              reload;
    logic [addr_w-1:0] last_addr;
    lsu_size_e         last_size;
    reload    = 1'b0;
    last_addr = '0;
    last_size = size_byte;
    for (int n = 0; n < n_ops; n++) begin
      if (reload) begin
        // Read back right away what the previous store wrote
        we     = 1'b0;
        addr   = last_addr;
        size   = last_size;
        reload = 1'b0;
      end else begin
        take_bits(lsu_lfsr, 2, v);
        if (v[1:0] == 2'd0) next_cycle();
        take_bits(lsu_lfsr, 1, v);
        we = v[0];
        take_bits(lsu_lfsr, 2, v);
        size = (v[1:0] == 2'd0) ? size_byte : (v[1:0] == 2'd1) ? size_half : size_word;
        take_bits(lsu_lfsr, 9, v);
        // Crossing accesses must not spill into the fetch region
        if (v[8:0] > 9'd507) v[8:0] = v[8:0] - 9'd256;
        addr = addr_w'(v[8:0]);
      end
      take_bits(lsu_lfsr, 32, v);
      lsu_access(we, size, addr, v);
      if (we) begin
        last_addr = addr;
        last_size = size;
        take_bits(lsu_lfsr, 1, v);
        reload = v[0];
      end
    end
  endtask

  task automatic fetch_traffic();
    logic [31:0] v;
    for (int n = 0; n < n_fetch; n++) begin
      take_bits(fetch_lfsr, 2, v);
      repeat (v[1:0]) next_cycle();
      take_bits(fetch_lfsr, 7, v);
      fetch_read((addr_w-2)'(fetch_base + int'(v[6:0])));
    end
  endtask

  initial begin
    rst_n        = 1'b0;
    lsu_req_i    = 1'b0;
    lsu_we_i     = 1'b0;
    lsu_size_i   = size_byte;
    lsu_addr_i   = '0;
    lsu_wdata_i  = '0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    end_check    = 1'b0;
    lsu_lfsr     = seed;
    fetch_lfsr   = seed;
    repeat (4) @(posedge clk);
    #drive_dly;
    rst_n = 1'b1;
    next_cycle();

    // Phase one fills every word, so the fetch region holds known data
    for (int k = 0; k < n_fill; k++) begin
      take_bits(lsu_lfsr, 32, bits);
      lsu_access(1'b1, size_word, addr_w'(4 * k), bits);
    end
    wait_ready();

    // Fetch stream starts from the LSU stream, shifted well away from it
    fetch_lfsr = lsu_lfsr;
    take_bits(lsu_lfsr, 32, bits);
    take_bits(lsu_lfsr, 32, bits);
    fork
      lsu_traffic();
      fetch_traffic();
    join

    // The last store response lands one cycle after the LSU frees up
    wait_ready();

    end_check = 1'b1;
    @(negedge clk);
    @(posedge clk);
    $display("Checks: %0d compared, %0d data errors, %0d protocol errors",
             checks, data_errs, proto_errs);
    if (data_errs == 0 && proto_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
